// File: common/mem_sys_pkg.sv
// Shared definitions for the cached memory system
// Address split, memory latency and the state, opcode and response encodings

package mem_sys_pkg;

   localparam int ADDR_W         = 16;
   localparam int WORD_W         = 16;
   localparam int TAG_W          = 5;
   localparam int INDEX_W        = 8;
   localparam int OFFSET_W       = 3;
   localparam int WORDS_PER_LINE = 4;
   localparam int WORD_SEL_W     = $clog2(WORDS_PER_LINE);

   // Backing memory timing and size
   localparam int MEM_LATENCY = 4;
   localparam int MEM_WORDS   = 32768;
   localparam int MEM_CNT_W   = $clog2(MEM_LATENCY + 1);

   typedef enum logic [1:0] {
      op_cmp_read,
      op_cmp_write,
      op_acc_read,
      op_acc_write
   } cache_op_e;

   typedef enum logic [2:0] {
      st_idle,
      st_lookup,
      st_wb_req,
      st_wb_wait,
      st_fill_req,
      st_fill_wait,
      st_resp
   } ctrl_state_e;

   // AXI response codes
   typedef enum logic [1:0] {
      resp_okay   = 2'b00,
      resp_slverr = 2'b10
   } resp_e;

endpackage

// File: common/cache_if.sv
// Request and result signals between the cache controller and the cache array
// Results are combinational from the request and the stored line

`timescale 1ns/1ns

interface cache_if;
   import mem_sys_pkg::*;

   logic               en;
   cache_op_e          op;
   logic [TAG_W-1:0]    tag;
   logic [INDEX_W-1:0]  index;
   logic [OFFSET_W-1:0] offset;
   logic [WORD_W-1:0]   wdata;

   logic [WORD_W-1:0]   rdata;
   logic [TAG_W-1:0]    tag_out;
   logic               hit;
   logic               valid;
   logic               dirty;
   logic               err;

   modport ctrl (
      output en, op, tag, index, offset, wdata,
      input  rdata, tag_out, hit, valid, dirty, err
   );

   modport array (
      input  en, op, tag, index, offset, wdata,
      output rdata, tag_out, hit, valid, dirty, err
   );

endinterface

// File: common/mem_if.sv
// Request and acknowledge signals between the cache controller and backing memory
// One request at a time, held until a single-cycle ack

`timescale 1ns/1ns

interface mem_if;
   import mem_sys_pkg::*;

   logic              req;
   logic              we;
   logic [ADDR_W-1:0] addr;
   logic [WORD_W-1:0] wdata;
   logic [WORD_W-1:0] rdata;
   logic              ack;

   modport master (
      output req, we, addr, wdata,
      input  rdata, ack
   );

   modport slave (
      input  req, we, addr, wdata,
      output rdata, ack
   );

endinterface

// File: cache/cache_ram.sv
// Indexed storage column for the cache array
// Combinational read, clocked write, all entries cleared on reset

`timescale 1ns/1ns

module cache_ram #(
   parameter int WIDTH = 16
) (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic [mem_sys_pkg::INDEX_W-1:0] index,
   input  logic [WIDTH-1:0]                wdata,
   input  logic                            we,
   output logic [WIDTH-1:0]                rdata
);
   import mem_sys_pkg::*;

   logic [WIDTH-1:0] mem [2**INDEX_W];

   assign rdata = mem[index];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < 2**INDEX_W; i++) begin
            mem[i] <= '0;
         end
      end else if (we) begin
         mem[index] <= wdata;
      end
   end

endmodule

// File: cache/cache_array.sv
// Direct-mapped cache storage with tag, data, valid and dirty columns
// Supports compare-read, compare-write, raw access read and line fill

`timescale 1ns/1ns

module cache_array (
   input logic   clk,
   input logic   rst_n,
   cache_if.array bus
);
   import mem_sys_pkg::*;

   logic [WORD_W-1:0]      words [WORDS_PER_LINE];
   logic [WORDS_PER_LINE-1:0] wr_word;
   logic [WORD_SEL_W-1:0]  word_sel;
   logic                   is_write;
   logic                   comp;
   logic                   match;
   logic                   wr_dirty;
   logic                   wr_line;
   logic                   dirty_bit;
   logic                   valid_bit;

   assign word_sel = bus.offset[OFFSET_W-1:1];
   assign is_write = (bus.op == op_cmp_write) || (bus.op == op_acc_write);
   assign comp     = (bus.op == op_cmp_write) || (bus.op == op_cmp_read);
   assign match    = (bus.tag == bus.tag_out);

   // A compare-write only lands on a tag match, a fill always lands
   assign wr_dirty = bus.en && is_write && (match || !comp);
   assign wr_line  = bus.en && (bus.op == op_acc_write);

   genvar w;
   generate
      for (w = 0; w < WORDS_PER_LINE; w++) begin : g_word
         assign wr_word[w] = wr_dirty && (word_sel == WORD_SEL_W'(w));

         cache_ram #(.WIDTH(WORD_W)) u_word (
            .clk   (clk),
            .rst_n (rst_n),
            .index (bus.index),
            .wdata (bus.wdata),
            .we    (wr_word[w]),
            .rdata (words[w])
         );
      end
   endgenerate

   cache_ram #(.WIDTH(TAG_W)) u_tag (
      .clk   (clk),
      .rst_n (rst_n),
      .index (bus.index),
      .wdata (bus.tag),
      .we    (wr_line),
      .rdata (bus.tag_out)
   );

   // Compare-write sets dirty, a fill clears it
   cache_ram #(.WIDTH(1)) u_dirty (
      .clk   (clk),
      .rst_n (rst_n),
      .index (bus.index),
      .wdata (comp),
      .we    (wr_dirty),
      .rdata (dirty_bit)
   );

   cache_ram #(.WIDTH(1)) u_valid (
      .clk   (clk),
      .rst_n (rst_n),
      .index (bus.index),
      .wdata (1'b1),
      .we    (wr_line),
      .rdata (valid_bit)
   );

   assign bus.err   = bus.offset[0];
   assign bus.hit   = bus.en && match && valid_bit;
   assign bus.valid = bus.en && valid_bit && (!is_write || comp);
   assign bus.dirty = bus.en && (!is_write || (comp && !match)) && dirty_bit;
   assign bus.rdata = (is_write || !bus.en) ? '0 : words[word_sel];

   // Controller must never issue a storage write for a misaligned address
   a_no_write_on_err : assert property (
      @(posedge clk) disable iff (!rst_n)
      bus.err |-> !(wr_dirty || wr_line)
   );

endmodule

// File: src/main_mem.sv
// Backing word memory behind the cache
// Serves one request at a time and acknowledges after a fixed latency

`timescale 1ns/1ns

module main_mem (
   input logic    clk,
   input logic    rst_n,
   mem_if.slave   bus
);
   import mem_sys_pkg::*;

   logic [WORD_W-1:0]    mem [MEM_WORDS];
   logic [ADDR_W-2:0]    word_addr;
   logic                 busy;
   logic [MEM_CNT_W-1:0] lat_cnt;

   // Word at byte address A starts out as the inverse of A
   initial begin
      for (int i = 0; i < MEM_WORDS; i++) begin
         mem[i] = ~WORD_W'(i << 1);
      end
   end

   assign word_addr = bus.addr[ADDR_W-1:1];
   assign bus.ack   = busy && (lat_cnt == MEM_CNT_W'(MEM_LATENCY));
   assign bus.rdata = mem[word_addr];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy    <= 1'b0;
         lat_cnt <= '0;
      end else if (busy) begin
         if (bus.ack) begin
            busy    <= 1'b0;
            lat_cnt <= '0;
         end else begin
            lat_cnt <= lat_cnt + 1'b1;
         end
      end else if (bus.req) begin
         busy    <= 1'b1;
         lat_cnt <= MEM_CNT_W'(1);
      end
   end

   // Write lands on the ack edge
   always @(posedge clk) begin
      if (bus.ack && bus.we) begin
         mem[word_addr] <= bus.wdata;
      end
   end

   a_req_stable : assert property (
      @(posedge clk) disable iff (!rst_n)
      bus.req && !bus.ack |=>
         bus.req && $stable(bus.addr) && $stable(bus.we) && $stable(bus.wdata)
   );

endmodule

// File: src/cache_ctrl.sv
// Cache controller with an AXI4-Lite slave port
// Runs lookups, dirty victim writebacks and line fills against backing memory

`timescale 1ns/1ns

module cache_ctrl (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic                           awvalid,
   output logic                           awready,
   input  logic [mem_sys_pkg::ADDR_W-1:0] awaddr,
   input  logic                           wvalid,
   output logic                           wready,
   input  logic [mem_sys_pkg::WORD_W-1:0] wdata,
   output logic                           bvalid,
   input  logic                           bready,
   output mem_sys_pkg::resp_e             bresp,
   input  logic                           arvalid,
   output logic                           arready,
   input  logic [mem_sys_pkg::ADDR_W-1:0] araddr,
   output logic                           rvalid,
   input  logic                           rready,
   output logic [mem_sys_pkg::WORD_W-1:0] rdata,
   output mem_sys_pkg::resp_e             rresp,
   cache_if.ctrl                          cbus,
   mem_if.master                          mbus
);
   import mem_sys_pkg::*;

   ctrl_state_e           state;
   logic [ADDR_W-1:0]     addr_q;
   logic [WORD_W-1:0]     wdata_q;
   logic [WORD_W-1:0]     rdata_q;
   logic                  is_write_q;
   resp_e                 resp_q;
   logic [WORD_SEL_W-1:0] word_cnt;
   logic                  last_word;
   logic                  rd_go;
   logic                  wr_go;
   logic [TAG_W-1:0]      req_tag;
   logic [INDEX_W-1:0]    req_index;
   logic [OFFSET_W-1:0]   req_offset;

   // Reads win, and a write needs AW and W together
   assign arready = (state == st_idle);
   assign awready = (state == st_idle) && !arvalid && wvalid;
   assign wready  = (state == st_idle) && !arvalid && awvalid;
   assign rd_go   = arvalid && arready;
   assign wr_go   = awvalid && awready && wvalid && wready;

   assign rvalid = (state == st_resp) && !is_write_q;
   assign bvalid = (state == st_resp) && is_write_q;
   assign rdata  = rdata_q;
   assign rresp  = resp_q;
   assign bresp  = resp_q;

   assign req_tag    = addr_q[ADDR_W-1 -: TAG_W];
   assign req_index  = addr_q[OFFSET_W +: INDEX_W];
   assign req_offset = addr_q[OFFSET_W-1:0];
   assign last_word  = (word_cnt == WORD_SEL_W'(WORDS_PER_LINE - 1));

   always_comb begin
      cbus.en     = 1'b0;
      cbus.op     = op_cmp_read;
      cbus.tag    = req_tag;
      cbus.index  = req_index;
      cbus.offset = req_offset;
      cbus.wdata  = wdata_q;
      mbus.req    = 1'b0;
      mbus.we     = 1'b0;
      mbus.addr   = {req_tag, req_index, word_cnt, 1'b0};
      mbus.wdata  = cbus.rdata;
      case (state)
         st_lookup: begin
            // Misaligned request never touches the array
            cbus.en = !req_offset[0];
            cbus.op = is_write_q ? op_cmp_write : op_cmp_read;
         end
         st_wb_req, st_wb_wait: begin
            cbus.en     = 1'b1;
            cbus.op     = op_acc_read;
            cbus.offset = {word_cnt, 1'b0};
            mbus.req    = 1'b1;
            mbus.we     = 1'b1;
            mbus.addr   = {cbus.tag_out, req_index, word_cnt, 1'b0};
         end
         st_fill_req, st_fill_wait: begin
            cbus.en     = (state == st_fill_wait) && mbus.ack;
            cbus.op     = op_acc_write;
            cbus.offset = {word_cnt, 1'b0};
            cbus.wdata  = mbus.rdata;
            mbus.req    = 1'b1;
         end
         default: begin
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state      <= st_idle;
         word_cnt   <= '0;
         is_write_q <= 1'b0;
         resp_q     <= resp_okay;
         rdata_q    <= '0;
      end else begin
         case (state)
            st_idle: begin
               if (rd_go || wr_go) begin
                  is_write_q <= !rd_go;
                  state      <= st_lookup;
               end
            end
            st_lookup: begin
               word_cnt <= '0;
               if (cbus.err) begin
                  resp_q  <= resp_slverr;
                  rdata_q <= '0;
                  state   <= st_resp;
               end else if (cbus.hit) begin
                  resp_q  <= resp_okay;
                  rdata_q <= cbus.rdata;
                  state   <= st_resp;
               end else if (cbus.valid && cbus.dirty) begin
                  state <= st_wb_req;
               end else begin
                  state <= st_fill_req;
               end
            end
            st_wb_req: state <= st_wb_wait;
            st_wb_wait: begin
               if (mbus.ack) begin
                  word_cnt <= word_cnt + 1'b1;
                  state    <= last_word ? st_fill_req : st_wb_req;
               end
            end
            st_fill_req: state <= st_fill_wait;
            st_fill_wait: begin
               if (mbus.ack) begin
                  word_cnt <= word_cnt + 1'b1;
                  state    <= last_word ? st_lookup : st_fill_req;
               end
            end
            st_resp: begin
               if ((rvalid && rready) || (bvalid && bready)) begin
                  state <= st_idle;
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (rd_go) begin
         addr_q <= araddr;
      end else if (wr_go) begin
         addr_q  <= awaddr;
         wdata_q <= wdata;
      end
   end

   a_rvalid_hold : assert property (
      @(posedge clk) disable iff (!rst_n)
      rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp)
   );

   a_bvalid_hold : assert property (
      @(posedge clk) disable iff (!rst_n)
      bvalid && !bready |=> bvalid && $stable(bresp)
   );

   // Memory must be quiet whenever the controller is idle
   a_no_req_idle : assert property (
      @(posedge clk) disable iff (!rst_n)
      state == st_idle |-> !mbus.req && !mbus.ack
   );

endmodule

// File: src/mem_system.sv
// Top level of the cached memory system
// AXI4-Lite slave in front of a direct-mapped write-back cache and backing memory

`timescale 1ns/1ns

module mem_system (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic                           awvalid,
   output logic                           awready,
   input  logic [mem_sys_pkg::ADDR_W-1:0] awaddr,
   input  logic                           wvalid,
   output logic                           wready,
   input  logic [mem_sys_pkg::WORD_W-1:0] wdata,
   output logic                           bvalid,
   input  logic                           bready,
   output mem_sys_pkg::resp_e             bresp,
   input  logic                           arvalid,
   output logic                           arready,
   input  logic [mem_sys_pkg::ADDR_W-1:0] araddr,
   output logic                           rvalid,
   input  logic                           rready,
   output logic [mem_sys_pkg::WORD_W-1:0] rdata,
   output mem_sys_pkg::resp_e             rresp
);

   cache_if cbus ();
   mem_if   mbus ();

   cache_ctrl u_ctrl (
      .clk     (clk),
      .rst_n   (rst_n),
      .awvalid (awvalid),
      .awready (awready),
      .awaddr  (awaddr),
      .wvalid  (wvalid),
      .wready  (wready),
      .wdata   (wdata),
      .bvalid  (bvalid),
      .bready  (bready),
      .bresp   (bresp),
      .arvalid (arvalid),
      .arready (arready),
      .araddr  (araddr),
      .rvalid  (rvalid),
      .rready  (rready),
      .rdata   (rdata),
      .rresp   (rresp),
      .cbus    (cbus.ctrl),
      .mbus    (mbus.master)
   );

   cache_array u_cache (
      .clk   (clk),
      .rst_n (rst_n),
      .bus   (cbus.array)
   );

   main_mem u_mem (
      .clk   (clk),
      .rst_n (rst_n),
      .bus   (mbus.slave)
   );

endmodule

// File: sim/mem_system_tb.sv
// Testbench for the cached memory system
// Replays the vector file over AXI4-Lite and checks every response against
// the file and against an inverse-address memory model

`timescale 1ns/1ns

module mem_system_tb;
   import mem_sys_pkg::*;

   localparam int    CLK_PERIOD = 100;
   localparam string VEC_FILE   = "sim/mem_system_vectors.txt";

   typedef struct {
      byte               op;
      logic [ADDR_W-1:0] addr;
      logic [WORD_W-1:0] wdata;
      logic [WORD_W-1:0] exp_data;
      resp_e             exp_resp;
   } vector_t;

   logic              clk;
   logic              rst_n;
   logic              awvalid;
   logic              awready;
   logic [ADDR_W-1:0] awaddr;
   logic              wvalid;
   logic              wready;
   logic [WORD_W-1:0] wdata;
   logic              bvalid;
   logic              bready;
   resp_e             bresp;
   logic              arvalid;
   logic              arready;
   logic [ADDR_W-1:0] araddr;
   logic              rvalid;
   logic              rready;
   logic [WORD_W-1:0] rdata;
   resp_e             rresp;

   vector_t           vecs[$];
   logic [WORD_W-1:0] model [logic [ADDR_W-1:0]];
   logic [31:0]       rng = 32'h2ab54546;
   int                cycles = 0;
   int                limit = 0;

   mem_system dut_i (.*);

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("Done: errors found");
      $fatal(1, "Simulation stopped");
   endtask

   task automatic check_data(input logic [WORD_W-1:0] got, input logic [WORD_W-1:0] exp,
                             input string what);
      if (got !== exp) begin
         fail_run($sformatf("ERROR at %0t ns: %s: got %h, expected %h", $time, what, got, exp));
      end
   endtask

   task automatic check_resp(input resp_e got, input resp_e exp, input string what);
      if (got !== exp) begin
         fail_run($sformatf("ERROR at %0t ns: %s: got %s, expected %s",
                            $time, what, got.name(), exp.name()));
      end
   endtask

   task automatic check_flag(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         fail_run($sformatf("ERROR at %0t ns: %s: got %b, expected %b", $time, what, got, exp));
      end
   endtask

   function automatic logic [31:0] next_random(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // Untouched words hold the inverse of their byte address
   function automatic logic [WORD_W-1:0] model_read(input logic [ADDR_W-1:0] addr);
      if (addr[0]) begin
         return '0;
      end
      if (!model.exists(addr)) begin
         model[addr] = ~addr;
      end
      return model[addr];
   endfunction

   task automatic load_vectors();
      int                fd;
      int                n;
      string             line;
      byte               op_c;
      logic [ADDR_W-1:0] a;
      logic [WORD_W-1:0] wd;
      logic [WORD_W-1:0] ed;
      logic [1:0]        er;
      vector_t           v;
      fd = $fopen(VEC_FILE, "r");
      if (fd == 0) begin
         fail_run("Could not open the vector file sim/mem_system_vectors.txt");
      end
      while (!$feof(fd)) begin
         line = "";
         void'($fgets(line, fd));
         if (line.len() < 2 || line.getc(0) == "#") begin
            continue;
         end
         n = $sscanf(line, "%c %h %h %h %h", op_c, a, wd, ed, er);
         if (n != 5) begin
            fail_run($sformatf("Malformed line in the vector file: %s", line));
         end
         v.op       = op_c;
         v.addr     = a;
         v.wdata    = wd;
         v.exp_data = ed;
         v.exp_resp = resp_e'(er);
         vecs.push_back(v);
      end
      $fclose(fd);
   endtask

   // Random ready delay, then one-cycle ready; payload must hold meanwhile
   task automatic do_read(input logic [ADDR_W-1:0] addr, output logic [WORD_W-1:0] data,
                          output resp_e resp);
      logic [WORD_W-1:0] first_data;
      resp_e             first_resp;
      int                delay;
      while (!arready) @(negedge clk);
      arvalid = 1'b1;
      araddr  = addr;
      @(negedge clk);
      if (arready) begin
         fail_run("The read request was not accepted while the controller was idle");
      end
      arvalid = 1'b0;
      while (!rvalid) @(negedge clk);
      first_data = rdata;
      first_resp = rresp;
      rng   = next_random(rng);
      delay = int'(rng[1:0]);
      repeat (delay) @(negedge clk);
      if (!rvalid) begin
         fail_run("rvalid dropped before rready was raised");
      end
      check_data(rdata, first_data, "read data held under back-pressure");
      check_resp(rresp, first_resp, "read response held under back-pressure");
      data   = rdata;
      resp   = rresp;
      rready = 1'b1;
      @(negedge clk);
      rready = 1'b0;
   endtask

   task automatic do_write(input logic [ADDR_W-1:0] addr, input logic [WORD_W-1:0] data,
                           output resp_e resp);
      resp_e first_resp;
      int    delay;
      while (!arready) @(negedge clk);
      awvalid = 1'b1;
      awaddr  = addr;
      wvalid  = 1'b1;
      wdata   = data;
      // Both write channels are taken together while idle
      #(CLK_PERIOD / 4);
      check_flag(awready, 1'b1, "awready with a write offered in idle");
      check_flag(wready, 1'b1, "wready with a write offered in idle");
      @(negedge clk);
      if (arready) begin
         fail_run("The write request was not accepted while the controller was idle");
      end
      check_flag(awready, 1'b0, "awready after the write was accepted");
      check_flag(wready, 1'b0, "wready after the write was accepted");
      awvalid = 1'b0;
      wvalid  = 1'b0;
      while (!bvalid) @(negedge clk);
      first_resp = bresp;
      rng   = next_random(rng);
      delay = int'(rng[1:0]);
      repeat (delay) @(negedge clk);
      if (!bvalid) begin
         fail_run("bvalid dropped before bready was raised");
      end
      check_resp(bresp, first_resp, "write response held under back-pressure");
      resp   = bresp;
      bready = 1'b1;
      @(negedge clk);
      bready = 1'b0;
   endtask

   task automatic run_vector(input vector_t v);
      logic [WORD_W-1:0] got_data;
      resp_e             got_resp;
      resp_e             model_resp;
      model_resp = v.addr[0] ? resp_slverr : resp_okay;
      if (v.op == "R") begin
         do_read(v.addr, got_data, got_resp);
         check_resp(got_resp, v.exp_resp, "read response vs vector file");
         check_resp(got_resp, model_resp, "read response vs model");
         check_data(got_data, v.exp_data, "read data vs vector file");
         check_data(got_data, model_read(v.addr), "read data vs model");
      end else if (v.op == "W") begin
         do_write(v.addr, v.wdata, got_resp);
         check_resp(got_resp, v.exp_resp, "write response vs vector file");
         check_resp(got_resp, model_resp, "write response vs model");
         if (model_resp == resp_okay) begin
            model[v.addr] = v.wdata;
         end
      end else begin
         fail_run($sformatf("Unknown operation '%c' in the vector file", v.op));
      end
   endtask

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (limit > 0 && cycles > limit) begin
         fail_run($sformatf("Timeout: the run did not finish within %0d cycles", limit));
      end
   end

   initial begin
      rst_n   = 1'b0;
      awvalid = 1'b0;
      awaddr  = '0;
      wvalid  = 1'b0;
      wdata   = '0;
      bready  = 1'b0;
      arvalid = 1'b0;
      araddr  = '0;
      rready  = 1'b0;
      load_vectors();
      limit = vecs.size() * (8 * MEM_LATENCY + 20) + 100;
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      foreach (vecs[i]) begin
         run_vector(vecs[i]);
      end
      if (vecs.size() > 0) begin
         $display("Done: no errors");
         $finish;
      end else begin
         fail_run("The vector file held no transactions");
      end
   end

endmodule

// File: sim/mem_system_vectors.txt
# op addr wdata exp_data exp_resp, all hex; exp_resp 0 is OKAY and 2 is SLVERR
# Write lines carry no read data, so their exp_data column stays 0000
R 0010 0000 FFEF 0
W 0020 1234 0000 0
R 0020 0000 1234 0
R 0022 0000 FFDD 0
R 0026 0000 FFD9 0
W 0040 ABCD 0000 0
R 0840 0000 F7BF 0
R 0040 0000 ABCD 0
R 0042 0000 FFBD 0
R 0840 0000 F7BF 0
R 0031 0000 0000 2
W 0033 5555 0000 2
R 0032 0000 FFCD 0
R 0030 0000 FFCF 0
W 0100 0F0F 0000 0
R 0100 0000 0F0F 0
W 0100 F0F0 0000 0
R 0100 0000 F0F0 0
R 1208 0000 EDF7 0
W 0208 7777 0000 0
R 020A 0000 FDF5 0
R 020C 0000 FDF3 0
R 0208 0000 7777 0
W 0300 3333 0000 0
R 0302 0000 FCFD 0
R 0300 0000 3333 0

// File: mem_system.f
common/mem_sys_pkg.sv
common/cache_if.sv
common/mem_if.sv
cache/cache_ram.sv
cache/cache_array.sv
src/main_mem.sv
src/cache_ctrl.sv
src/mem_system.sv
sim/mem_system_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP      = mem_system_tb
FILELIST = mem_system.f

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
